// ==== compile.f ====
+incdir+dv
source/physics_pkg.sv
source/motion_if.sv
source/param_if.sv
source/controller_decode.sv
source/signed_divider.sv
source/motion_integrator.sv
source/wb_register_file.sv
source/physics_coprocessor.sv
dv/physics_tb.sv

// ==== dv/physics_ref_model.svh ====
// Expected physics state
fix_t exp_pos_x;
fix_t exp_pos_y;
fix_t exp_vel_x;
fix_t exp_vel_y;
logic exp_attack_prev;

// Register shadows as the next tick samples them
logic [MASS_WIDTH-1:0] sh_mass;
fix_t sh_gravity;
fix_t sh_jump;
logic [31:0] sh_start;
logic sh_freeze;
logic sh_reload; // Written but not yet used by a step

// Inputs of the step in flight
logic [31:0] in_ctrl;
logic [WALL_BITS-1:0] in_wall;
logic [31:0] in_knock;
logic in_attack;
logic in_jump; // New press since the last step
logic prev_cond;

function automatic fix_t div_toward_zero(input fix_t num, input logic [MASS_WIDTH-1:0] den);
	longint n;
	longint d;
	n = num;
	d = (den == '0) ? 64'sd1 : longint'(den); // Zero mass acts as one
	return fix_t'(n / d);
endfunction

function automatic fix_t q8_8_to_fix(input logic [15:0] half);
	fix_t whole;
	whole = fix_t'(signed'(half));
	return whole * 256; // Eight more fraction bits
endfunction

function automatic logic [31:0] expected_position();
	return {exp_pos_x[31:16], exp_pos_y[31:16]};
endfunction

function automatic void step_model();
	int move;
	fix_t target;
	fix_t vx;
	fix_t vy;
	logic drop;
	logic grounded;
	logic reload;
	move = (int'(in_ctrl[15:8]) - JOY_CENTER) * (1 << MOVE_SHIFT);
	target = div_toward_zero(fix_t'(move), sh_mass);
	drop = in_ctrl[7:0] <= JOY_DOWN_MAX;
	grounded = in_wall[WALL_DOWN] | (in_wall[WALL_PLATFORM] & ~drop);
	reload = sh_reload;
	sh_reload = 1'b0; // Consumed by this tick even when frozen
	if (sh_freeze)
		return;
	if (reload) begin
		exp_vel_x = '0;
		exp_vel_y = '0;
		exp_pos_x = {sh_start[31:16], 16'h0000};
		exp_pos_y = {sh_start[15:0], 16'h0000};
	end else begin
		if (in_attack) begin
			vx = q8_8_to_fix(in_knock[31:16]);
			vy = q8_8_to_fix(in_knock[15:0]);
		end else if (!grounded) begin
			vx = exp_vel_x;
			if (vx < target)
				vx = vx + 1;
			else if (vx > target)
				vx = vx - 1;
			vy = exp_vel_y - sh_gravity;
		end else begin
			vx = target;
			vy = in_jump ? div_toward_zero(sh_jump, sh_mass) : fix_t'(0);
		end
		if (in_wall[WALL_LEFT] && vx < 0)
			vx = '0;
		if (in_wall[WALL_RIGHT] && vx > 0)
			vx = '0;
		if (in_wall[WALL_UP] && vy > 0)
			vy = '0;
		exp_pos_x = exp_pos_x + vx;
		exp_pos_y = exp_pos_y + vy;
		if (in_attack && !exp_attack_prev)
			exp_pos_y = exp_pos_y + KNOCK_LIFT; // Lift on the first attack tick
		exp_vel_x = vx;
		exp_vel_y = vy;
	end
	exp_attack_prev = in_attack;
endfunction

// ==== dv/physics_tb.sv ====
module physics_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import physics_pkg::*;

	logic clock;
	logic reset;
	logic [31:0] controller_in;
	logic [WALL_BITS-1:0] wall;
	logic [31:0] knockback_in;
	logic attack_in;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [WB_ADR_WIDTH-1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic [31:0] position;
	logic step_done;

	`include "physics_ref_model.svh"

	physics_coprocessor u_dut (.*);

	always #20 clock = ~clock;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_fix(input string name, input fix_t expected, input fix_t actual);
		if (actual !== expected)
			stop_run($sformatf("ERROR %0t %s expected %h actual %h", $time, name, expected, actual));
	endtask

	task automatic check_position(input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
			stop_run($sformatf("ERROR %0t position expected %h actual %h", $time, expected, actual));
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			stop_run($sformatf("ERROR %0t %s expected %h actual %h", $time, name, expected, actual));
	endtask

	task automatic wait_ack(input string what);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles > 16)
				stop_run($sformatf("Timeout waiting for the Wishbone ack of a %s", what));
		end while (!wb_ack);
	endtask

	task automatic wait_step_done();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles > 4 * TICK_CYCLES)
				stop_run("Timeout waiting for step_done");
		end while (!step_done);
	endtask

	task automatic wb_write(input logic [WB_ADR_WIDTH-1:0] adr, input logic [31:0] data);
		@(posedge clock);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= adr;
		wb_dat_w <= data;
		wait_ack("write");
		@(posedge clock);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_read(input logic [WB_ADR_WIDTH-1:0] adr, output logic [31:0] data);
		@(posedge clock);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= adr;
		wait_ack("read");
		data = wb_dat_r; // Held with ack
		@(posedge clock);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	// Bus write that the model follows
	task automatic write_reg(input logic [WB_ADR_WIDTH-1:0] adr, input logic [31:0] data);
		wb_write(adr, data);
		case (adr)
			REG_MASS: sh_mass = data[MASS_WIDTH-1:0];
			REG_GRAVITY: sh_gravity = data;
			REG_JUMP: sh_jump = data;
			REG_START: sh_start = data;
			REG_CONTROL: begin
				sh_freeze = data[CTRL_FREEZE];
				sh_reload = sh_reload | data[CTRL_RELOAD];
			end
			default: ;
		endcase
	endtask

	task automatic check_registers();
		logic [31:0] data;
		logic [31:0] value;
		for (int a = 0; a < 8; a++) begin
			wb_read(WB_ADR_WIDTH'(a), data);
			check_word($sformatf("reset value of register %0d", a),
				(a == REG_MASS) ? 32'd1 : 32'd0, data);
		end
		repeat (4) begin
			for (int a = REG_MASS; a <= REG_START; a++) begin
				value = $urandom;
				wb_write(WB_ADR_WIDTH'(a), value);
				wb_read(WB_ADR_WIDTH'(a), data);
				check_word($sformatf("register %0d", a),
					(a == REG_MASS) ? {16'h0000, value[15:0]} : value, data);
			end
		end
		// Control is write only and status ignores writes
		wb_write(REG_CONTROL, 32'h0);
		for (int a = REG_CONTROL; a <= REG_VEL_Y; a++) begin
			if (a != REG_CONTROL)
				wb_write(WB_ADR_WIDTH'(a), $urandom);
			wb_read(WB_ADR_WIDTH'(a), data);
			check_word($sformatf("register %0d", a), 32'd0, data);
		end
	endtask

	task automatic check_status();
		logic [31:0] data;
		wb_read(REG_VEL_X, data);
		check_fix("vel_x", exp_vel_x, fix_t'(data));
		wb_read(REG_VEL_Y, data);
		check_fix("vel_y", exp_vel_y, fix_t'(data));
		wb_read(REG_POSITION, data);
		check_word("position register", expected_position(), data);
	endtask

	// Called in the step_done cycle and drives at the next edge
	task automatic start_step(input logic [31:0] ctrl, input logic [WALL_BITS-1:0] wl,
			input logic [31:0] kb, input logic atk);
		logic cond;
		@(posedge clock);
		controller_in <= ctrl;
		wall <= wl;
		knockback_in <= kb;
		attack_in <= atk;
		in_ctrl = ctrl;
		in_wall = wl;
		in_knock = kb;
		in_attack = atk;
		cond = ctrl[JUMP_BUTTON] | (ctrl[7:0] >= JOY_UP_MIN);
		in_jump = cond & ~prev_cond;
		prev_cond = cond;
		check_status(); // Still the previous step
	endtask

	task automatic finish_step();
		wait_step_done();
		step_model();
		check_position(expected_position(), position);
	endtask

	task automatic run_step(input logic [31:0] ctrl, input logic [WALL_BITS-1:0] wl,
			input logic [31:0] kb, input logic atk);
		start_step(ctrl, wl, kb, atk);
		finish_step();
	endtask

	function automatic logic [31:0] random_controller();
		logic [7:0] x;
		logic [7:0] y;
		logic button;
		case ($urandom % 4)
			0: y = 8'($urandom % 16); // Stick down drops through
			1: y = 8'(240 + $urandom % 16); // Up counts as jump
			default: y = 8'(16 + $urandom % 224);
		endcase
		x = 8'($urandom);
		button = ($urandom % 4) == 0;
		return {7'b0, button, 8'h00, x, y};
	endfunction

	task automatic random_write();
		logic [31:0] mass;
		mass = ($urandom % 8 == 0) ? 32'd0 : 32'(1 + $urandom % 300);
		case ($urandom % 6)
			0: write_reg(REG_MASS, mass);
			1: write_reg(REG_GRAVITY, $urandom % 32'h4000);
			2: write_reg(REG_JUMP, 32'h0002_0000 + $urandom % 32'h0008_0000);
			3: write_reg(REG_START, $urandom);
			4: write_reg(REG_CONTROL, ($urandom % 3 == 0) ? 32'h1 : 32'h0);
			default: write_reg(REG_CONTROL, 32'h2); // Reload
		endcase
	endtask

	initial begin
		logic [31:0] ctrl;
		logic [WALL_BITS-1:0] wl;
		logic [31:0] kb;
		logic atk;
		void'($urandom(7));
		clock = 1'b0;
		reset = 1'b1;
		controller_in = 32'h0000_8080; // Stick at rest
		wall = 5'b00010; // Standing on ground
		knockback_in = '0;
		attack_in = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		sh_reload = 1'b0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		check_registers();

		// Idle steps keep the state so two steps always include the reload
		write_reg(REG_MASS, 32'(1 + $urandom % 8));
		write_reg(REG_GRAVITY, $urandom % 32'h4000);
		write_reg(REG_JUMP, 32'h0004_0000 + $urandom % 32'h0004_0000);
		write_reg(REG_START, $urandom);
		write_reg(REG_CONTROL, 32'h2);
		wait_step_done();
		wait_step_done();
		exp_vel_x = '0;
		exp_vel_y = '0;
		exp_pos_x = {sh_start[31:16], 16'h0000};
		exp_pos_y = {sh_start[15:0], 16'h0000};
		exp_attack_prev = 1'b0;
		sh_reload = 1'b0;
		prev_cond = 1'b0;

		run_step(32'h0000_C080, 5'b00010, '0, 1'b0);
		run_step(32'h0100_8080, 5'b00010, '0, 1'b0); // Jump press
		run_step(32'h0100_8080, 5'b00010, '0, 1'b0);
		run_step(32'h0000_80F8, 5'b00010, '0, 1'b0); // Still held by stick
		run_step(32'h0000_3080, 5'b00000, '0, 1'b0);
		run_step(32'h0000_4005, 5'b10000, '0, 1'b0); // Drop through platform
		run_step(32'h0000_4080, 5'b10000, '0, 1'b0);
		run_step(32'h0000_8080, 5'b01101, 32'hFF80_0100, 1'b1);
		run_step(32'h0000_8080, 5'b00110, 32'h0200_FE00, 1'b1);
		start_step(random_controller(), 5'b00000, $urandom, 1'b0);
		write_reg(REG_CONTROL, 32'h1);
		finish_step();
		repeat (3)
			run_step(random_controller(), 5'b00000, $urandom, 1'b1);
		start_step(32'h0000_8080, 5'b00010, '0, 1'b0);
		write_reg(REG_CONTROL, 32'h0);
		finish_step();

		atk = 1'b0;
		repeat (300) begin
			ctrl = random_controller();
			wl = WALL_BITS'($urandom);
			kb = $urandom;
			if ($urandom % 3 == 0)
				atk = ~atk;
			start_step(ctrl, wl, kb, atk);
			if ($urandom % 4 == 0)
				random_write();
			finish_step();
		end
		check_status(); // Velocities of the last step
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== source/physics_coprocessor.sv ====
module physics_coprocessor (
	input logic clock,
	input logic reset,
	input logic [31:0] controller_in,
	input logic [physics_pkg::WALL_BITS-1:0] wall,
	input logic [31:0] knockback_in,
	input logic attack_in,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [physics_pkg::WB_ADR_WIDTH-1:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	output logic [31:0] position, // X integer high, Y integer low
	output logic step_done
);
	import physics_pkg::*;

	motion_if cmd_bus ();
	param_if param_bus ();

	controller_decode u_decode (
		.clock(clock),
		.reset(reset),
		.controller_in(controller_in),
		.cmd(cmd_bus.source),
		.step_done(step_done)
	);

	motion_integrator u_integrator (
		.clock(clock),
		.reset(reset),
		.cmd(cmd_bus.sink),
		.params(param_bus.integrator),
		.wall(wall),
		.knockback_in(knockback_in),
		.attack_in(attack_in),
		.step_done(step_done)
	);

	wb_register_file u_regs (
		.clock(clock),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.params(param_bus.register)
	);

	// Same packing as the status register
	assign position = pack_position(param_bus.pos_x, param_bus.pos_y);

endmodule

// ==== source/wb_register_file.sv ====
module wb_register_file (
	input logic clock,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [physics_pkg::WB_ADR_WIDTH-1:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	param_if.register params
);
	import physics_pkg::*;

	logic request;
	logic accept;
	logic served; // Strobe already answered

	assign request = wb_cyc & wb_stb;
	assign accept = request & ~wb_ack & ~served;

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_ack <= 1'b0;
			served <= 1'b0;
			params.mass <= MASS_WIDTH'(1);
			params.gravity <= '0;
			params.jump_impulse <= '0;
			params.start_position <= '0;
			params.freeze <= 1'b0;
			params.reload <= 1'b0;
		end else begin
			wb_ack <= accept;
			served <= request & (served | wb_ack); // Held until stb drops
			params.reload <= 1'b0;
			if (accept && wb_we) begin
				case (wb_adr)
					REG_MASS: params.mass <= wb_dat_w[MASS_WIDTH-1:0];
					REG_GRAVITY: params.gravity <= wb_dat_w;
					REG_JUMP: params.jump_impulse <= wb_dat_w;
					REG_START: params.start_position <= wb_dat_w;
					REG_CONTROL: begin
						params.freeze <= wb_dat_w[CTRL_FREEZE];
						params.reload <= wb_dat_w[CTRL_RELOAD];
					end
					default: ; // Status words ignore writes
				endcase
			end
		end
	end

	// Read mux, sampled by the master with ack
	always_comb begin
		case (wb_adr)
			REG_MASS: wb_dat_r = 32'(params.mass);
			REG_GRAVITY: wb_dat_r = params.gravity;
			REG_JUMP: wb_dat_r = params.jump_impulse;
			REG_START: wb_dat_r = params.start_position;
			REG_POSITION: wb_dat_r = pack_position(params.pos_x, params.pos_y);
			REG_VEL_X: wb_dat_r = params.vel_x;
			REG_VEL_Y: wb_dat_r = params.vel_y;
			default: wb_dat_r = '0; // Control reads back as zero
		endcase
	end

	a_ack_in_cycle: assert property (@(posedge clock) disable iff (reset)
		wb_ack |-> wb_cyc && wb_stb);

endmodule

// ==== source/motion_integrator.sv ====
module motion_integrator (
	input logic clock,
	input logic reset,
	motion_if.sink cmd,
	param_if.integrator params,
	input logic [physics_pkg::WALL_BITS-1:0] wall,
	input logic [31:0] knockback_in,
	input logic attack_in,
	output logic step_done
);
	import physics_pkg::*;

	integ_state_t state;
	logic [$clog2(TICK_CYCLES)-1:0] tick_count;
	logic tick;
	logic step_start;

	// Sampled at the start of a step
	logic [WALL_BITS-1:0] wall_s;
	logic [31:0] knock_s;
	logic attack_s;
	logic jump_s;
	logic drop_s;
	logic freeze_s;
	logic reload_s;
	fix_t gravity_s;
	fix_t jump_imp_s;
	logic [MASS_WIDTH-1:0] mass_s;
	logic [31:0] start_s;

	logic reload_pend;
	logic attack_prev;
	fix_t target_x;
	fix_t jump_vel;
	fix_t pos_x;
	fix_t pos_y;
	fix_t vel_x;
	fix_t vel_y;
	fix_t vx_next;
	fix_t vy_next;
	fix_t knock_x;
	fix_t knock_y;
	fix_t move_dividend;
	logic grounded;
	logic attack_rise;
	logic take_jump;

	logic div_start;
	logic div_done;
	fix_t div_dividend;
	fix_t div_quotient;
	logic [MASS_WIDTH-1:0] div_divisor;

	assign tick = tick_count == TICK_CYCLES - 1;
	assign step_start = tick && state == IDLE; // Busy ticks are lost

	assign grounded = wall_s[WALL_DOWN] | (wall_s[WALL_PLATFORM] & ~drop_s);
	assign attack_rise = attack_s & ~attack_prev;
	assign take_jump = grounded & jump_s;

	// Q8.8 halves widened to Q16.16
	assign knock_x = fix_t'($signed(knock_s[31:16])) <<< (FRAC_BITS - KNOCK_FRAC);
	assign knock_y = fix_t'($signed(knock_s[15:0])) <<< (FRAC_BITS - KNOCK_FRAC);

	assign move_dividend = fix_t'(cmd.move_x) <<< MOVE_SHIFT;
	assign div_start = step_start || (state == DIV_X && div_done && take_jump);
	assign div_dividend = (state == IDLE) ? move_dividend : jump_imp_s;
	assign div_divisor = (state == IDLE) ? params.mass : mass_s;

	signed_divider u_divider (
		.clock(clock),
		.reset(reset),
		.start(div_start),
		.dividend(div_dividend),
		.divisor(div_divisor),
		.quotient(div_quotient),
		.busy(),
		.done(div_done)
	);

	always_comb begin
		vx_next = vel_x;
		vy_next = vel_y;
		if (attack_s) begin
			vx_next = knock_x; // First and held attack tick alike
			vy_next = knock_y;
		end else if (!grounded) begin
			if (vel_x < target_x)
				vx_next = vel_x + fix_t'(1);
			else if (vel_x > target_x)
				vx_next = vel_x - fix_t'(1);
			vy_next = vel_y - gravity_s;
		end else begin
			vx_next = target_x;
			vy_next = jump_s ? jump_vel : '0;
		end
		// Walls stop motion into them
		if (wall_s[WALL_LEFT] && vx_next < 0)
			vx_next = '0;
		if (wall_s[WALL_RIGHT] && vx_next > 0)
			vx_next = '0;
		if (wall_s[WALL_UP] && vy_next > 0)
			vy_next = '0;
	end

	always_ff @(posedge clock) begin
		if (step_start) begin
			wall_s <= wall;
			knock_s <= knockback_in;
			attack_s <= attack_in;
			jump_s <= cmd.jump_req;
			drop_s <= cmd.drop_thru;
			freeze_s <= params.freeze;
			reload_s <= reload_pend | params.reload;
			gravity_s <= params.gravity;
			jump_imp_s <= params.jump_impulse;
			mass_s <= params.mass;
			start_s <= params.start_position;
		end
		if (state == DIV_X && div_done)
			target_x <= div_quotient;
		if (state == DIV_JUMP && div_done)
			jump_vel <= div_quotient;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			tick_count <= '0;
			step_done <= 1'b0;
			reload_pend <= 1'b0;
			attack_prev <= 1'b0;
			vel_x <= '0;
			vel_y <= '0;
			pos_x <= fix_t'({params.start_position[31:16], {FRAC_BITS{1'b0}}});
			pos_y <= fix_t'({params.start_position[15:0], {FRAC_BITS{1'b0}}});
		end else begin
			tick_count <= tick_count + 1'b1;
			step_done <= state == UPDATE;
			if (step_start)
				reload_pend <= 1'b0;
			else if (params.reload)
				reload_pend <= 1'b1; // Waits for the next step
			case (state)
				IDLE: if (tick) state <= DIV_X;
				DIV_X: if (div_done) state <= take_jump ? DIV_JUMP : UPDATE;
				DIV_JUMP: if (div_done) state <= UPDATE;
				default: state <= IDLE;
			endcase
			if (state == UPDATE && !freeze_s) begin
				attack_prev <= attack_s;
				if (reload_s) begin
					vel_x <= '0;
					vel_y <= '0;
					pos_x <= fix_t'({start_s[31:16], {FRAC_BITS{1'b0}}});
					pos_y <= fix_t'({start_s[15:0], {FRAC_BITS{1'b0}}});
				end else begin
					vel_x <= vx_next;
					vel_y <= vy_next;
					pos_x <= pos_x + vx_next;
					// Attack start also lifts the character
					pos_y <= pos_y + vy_next + (attack_rise ? KNOCK_LIFT : fix_t'(0));
				end
			end
		end
	end

	assign params.pos_x = pos_x;
	assign params.pos_y = pos_y;
	assign params.vel_x = vel_x;
	assign params.vel_y = vel_y;

	// Divider results only arrive while a division is awaited
	a_done_awaited: assert property (@(posedge clock) disable iff (reset)
		div_done |-> state == DIV_X || state == DIV_JUMP);

endmodule

// ==== source/signed_divider.sv ====
module signed_divider (
	input logic clock,
	input logic reset,
	input logic start,
	input physics_pkg::fix_t dividend,
	input logic [physics_pkg::MASS_WIDTH-1:0] divisor,
	output physics_pkg::fix_t quotient,
	output logic busy,
	output logic done
);
	import physics_pkg::*;

	logic [DIV_WIDTH-1:0] work; // Dividend magnitude, quotient bits shift in
	logic [MASS_WIDTH-1:0] rem;
	logic [MASS_WIDTH-1:0] dvs;
	logic negative;
	logic [$clog2(DIV_WIDTH):0] count;
	logic [MASS_WIDTH:0] shifted;
	logic [MASS_WIDTH+1:0] trial;

	// One restoring step
	assign shifted = {rem, work[DIV_WIDTH-1]};
	assign trial = {1'b0, shifted} - {2'b00, dvs};

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy) begin
				if (count == DIV_WIDTH) begin
					busy <= 1'b0; // Sign fixup cycle
					done <= 1'b1;
				end else begin
					count <= count + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			work <= dividend[DIV_WIDTH-1] ? -dividend : dividend;
			rem <= '0;
			dvs <= (divisor == '0) ? MASS_WIDTH'(1) : divisor; // Zero acts as one
			negative <= dividend[DIV_WIDTH-1];
		end else if (busy && count != DIV_WIDTH) begin
			if (trial[MASS_WIDTH+1]) begin
				rem <= shifted[MASS_WIDTH-1:0]; // Restore
				work <= {work[DIV_WIDTH-2:0], 1'b0};
			end else begin
				rem <= trial[MASS_WIDTH-1:0];
				work <= {work[DIV_WIDTH-2:0], 1'b1};
			end
		end else if (busy) begin
			// Truncates toward zero
			quotient <= negative ? -fix_t'(work) : fix_t'(work);
		end
	end

	// The integrator only starts a division once the last one finished
	a_no_restart: assert property (@(posedge clock) disable iff (reset)
		busy |-> !start);

endmodule

// ==== source/controller_decode.sv ====
module controller_decode (
	input logic clock,
	input logic reset,
	input logic [31:0] controller_in,
	motion_if.source cmd,
	input logic step_done
);
	import physics_pkg::*;

	logic [7:0] joy_x;
	logic [7:0] joy_y;
	logic jump_cond;
	logic jump_prev; // Jump condition one cycle back

	assign joy_x = controller_in[15:8];
	assign joy_y = controller_in[7:0];

	// Raw joystick runs 0 to 255 with rest at the centre
	assign cmd.move_x = {1'b0, joy_x} - JOY_WIDTH'(JOY_CENTER);
	assign cmd.move_y = {1'b0, joy_y} - JOY_WIDTH'(JOY_CENTER);

	assign cmd.drop_thru = joy_y <= 8'(JOY_DOWN_MAX);

	// Button or stick held up
	assign jump_cond = controller_in[JUMP_BUTTON] | (joy_y >= 8'(JOY_UP_MIN));

	always_ff @(posedge clock) begin
		if (reset) begin
			jump_prev <= 1'b0;
			cmd.jump_req <= 1'b0;
		end else begin
			jump_prev <= jump_cond;
			if (step_done)
				cmd.jump_req <= 1'b0; // Step has used it
			else if (jump_cond && !jump_prev)
				cmd.jump_req <= 1'b1; // New press only
		end
	end

	// One finished step clears the request with a single pulse
	a_done_pulse: assert property (@(posedge clock) disable iff (reset)
		step_done |=> !step_done);

endmodule

// ==== source/param_if.sv ====
interface param_if;
	import physics_pkg::*;

	// Tuning constants and controls
	logic [MASS_WIDTH-1:0] mass;
	fix_t gravity;
	fix_t jump_impulse;
	logic [31:0] start_position; // X integer high, Y integer low
	logic freeze;
	logic reload; // Single cycle pulse

	// Physics state for readback
	fix_t pos_x;
	fix_t pos_y;
	fix_t vel_x;
	fix_t vel_y;

	modport integrator (
		input mass, gravity, jump_impulse, start_position, freeze, reload,
		output pos_x, pos_y, vel_x, vel_y
	);

	modport register (
		output mass, gravity, jump_impulse, start_position, freeze, reload,
		input pos_x, pos_y, vel_x, vel_y
	);

endinterface

// ==== source/motion_if.sv ====
interface motion_if;
	import physics_pkg::*;

	logic signed [JOY_WIDTH-1:0] move_x; // Joystick minus rest value
	logic signed [JOY_WIDTH-1:0] move_y;
	logic jump_req; // Held until a step finishes
	logic drop_thru; // Stick pushed down

	modport source (
		output move_x,
		output move_y,
		output jump_req,
		output drop_thru
	);

	modport sink (
		input move_x,
		input move_y,
		input jump_req,
		input drop_thru
	);

endinterface

// ==== source/physics_pkg.sv ====
package physics_pkg;

	// Word and field widths
	localparam int FIX_WIDTH = 32;
	localparam int FRAC_BITS = 16; // Q16.16
	localparam int DIV_WIDTH = 32;
	localparam int MASS_WIDTH = 16;
	localparam int JOY_WIDTH = 9; // Centred joystick, signed
	localparam int WALL_BITS = 5;
	localparam int WB_ADR_WIDTH = 3;

	localparam int TICK_CYCLES = 64; // Clocks per physics step
	localparam int MOVE_SHIFT = 10;

	// Controller decoding
	localparam int JOY_CENTER = 128;
	localparam int JOY_UP_MIN = 240;
	localparam int JOY_DOWN_MAX = 15;
	localparam int JUMP_BUTTON = 24;

	// Collision flag positions
	localparam int WALL_UP = 0;
	localparam int WALL_DOWN = 1;
	localparam int WALL_RIGHT = 2;
	localparam int WALL_LEFT = 3;
	localparam int WALL_PLATFORM = 4;

	typedef logic signed [FIX_WIDTH-1:0] fix_t;

	localparam fix_t KNOCK_LIFT = 32'sh0008_0000; // 8.0
	localparam int KNOCK_FRAC = 8; // Knockback halves are Q8.8

	// Register word addresses
	localparam logic [WB_ADR_WIDTH-1:0] REG_MASS = WB_ADR_WIDTH'(0);
	localparam logic [WB_ADR_WIDTH-1:0] REG_GRAVITY = WB_ADR_WIDTH'(1);
	localparam logic [WB_ADR_WIDTH-1:0] REG_JUMP = WB_ADR_WIDTH'(2);
	localparam logic [WB_ADR_WIDTH-1:0] REG_START = WB_ADR_WIDTH'(3);
	localparam logic [WB_ADR_WIDTH-1:0] REG_CONTROL = WB_ADR_WIDTH'(4);
	localparam logic [WB_ADR_WIDTH-1:0] REG_POSITION = WB_ADR_WIDTH'(5);
	localparam logic [WB_ADR_WIDTH-1:0] REG_VEL_X = WB_ADR_WIDTH'(6);
	localparam logic [WB_ADR_WIDTH-1:0] REG_VEL_Y = WB_ADR_WIDTH'(7);

	localparam int CTRL_FREEZE = 0;
	localparam int CTRL_RELOAD = 1;

	typedef enum logic [1:0] {IDLE, DIV_X, DIV_JUMP, UPDATE} integ_state_t;

	// Integer parts of X and Y side by side
	function automatic logic [31:0] pack_position(input fix_t x, input fix_t y);
		return {x[FIX_WIDTH-1:FRAC_BITS], y[FIX_WIDTH-1:FRAC_BITS]};
	endfunction

endpackage
